/* src.f */
logic/ucodePkg.sv
logic/opcodeLut.sv
logic/ucodeRom.sv
logic/ucodeSequencer.sv
logic/cpuDatapath.sv
logic/hostRegs.sv
logic/gbCore.sv
sim/gbCore_chk.sv
sim/gbCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the gbCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module gbCoreTb -f src.f \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/VgbCoreTb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -qx "all tests passed" sim.log && echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }

/* sim/gbCoreTb.sv */
`timescale 1ns/1ps

module gbCoreTb;
	import ucodePkg::*;

	// Not in the opcode table
	localparam Byte BadOp = 8'hD3;
	localparam int ApbTimeout = 8;
	localparam int HaltPolls = 300;

	logic clock;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	ApbAddr paddr;
	ApbData pwdata;
	ApbData prdata;
	logic pready;
	logic pslverr;
	Addr memAddr;
	logic memWrite;
	Byte memWdata;
	Byte memRdata;

	Byte mem [0:65535];
	Addr loadPtr;
	int valueErrors;
	int timeoutErrors;

	gbCore #(.RetiredWidth(16)) uut (.*);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Memory model with one cycle read latency
	always @(posedge clock)
	begin
		if (memWrite)
			mem[memAddr] <= memWdata;
		memRdata <= mem[memAddr];
	end

	////////////////////
	// Helpers

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected)
		else
		begin
			$error("ERROR t=%0t %s expected %0h got %0h", $time, name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic apbAccess(input logic write, input ApbAddr addr, input ApbData data,
		output ApbData rdata, output logic err);
		int waitCount;
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);
		waitCount = 0;
		while (!pready && waitCount < ApbTimeout)
		begin
			@(negedge clock);
			waitCount++;
		end
		if (!pready)
		begin
			$display("Timeout: APB access to address %0h never saw pready", addr);
			timeoutErrors++;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input ApbAddr addr, input ApbData data);
		ApbData ignoredData;
		logic ignoredErr;
		apbAccess(1'b1, addr, data, ignoredData, ignoredErr);
	endtask

	task automatic apbRead(input ApbAddr addr, output ApbData rdata, output logic err);
		apbAccess(1'b0, addr, '0, rdata, err);
	endtask

	task automatic putByte(input Byte value);
		mem[loadPtr] = value;
		loadPtr = loadPtr + 16'd1;
	endtask

	// Low byte first
	task automatic putWord(input Addr value);
		putByte(value[7:0]);
		putByte(value[15:8]);
	endtask

	task automatic startCore(input Addr base);
		apbWrite(StartPcAddr, ApbData'(base));
		apbWrite(CtrlAddr, 32'h1);
	endtask

	task automatic waitHalt();
		ApbData status;
		logic err;
		int polls;
		status = '0;
		polls = 0;
		while (!status[0] && polls < HaltPolls)
		begin
			apbRead(StatusAddr, status, err);
			polls++;
		end
		if (!status[0])
		begin
			$display("Timeout: core did not halt within %0d status polls", HaltPolls);
			timeoutErrors++;
		end
	endtask

	task automatic watchNoWrite(input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			checkValue("memWrite", 32'h0, memWrite);
		end
	endtask

	////////////////////
	// Programs

	initial
	begin
		Addr base;
		Addr dataAddr;
		Byte n;
		Byte m;
		Byte x;
		Byte y;
		Byte k;
		Byte expSum;
		Byte expDiff;
		ApbData rd;
		logic err;
		int waitCount;
		int chkFailures;

		void'($urandom(77629));
		valueErrors = 0;
		timeoutErrors = 0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		memRdata = '0;
		loadPtr = '0;
		for (int i = 0; i < 65536; i++)
			mem[i] = Byte'(i[15:8] ^ i[7:0] ^ 8'hA5);
		repeat (10) @(posedge clock);
		rst <= 1'b0;

		// Idle after reset and the register map
		watchNoWrite(20);
		apbRead(CtrlAddr, rd, err);
		checkValue("prdata(ctrl)", 32'h0, rd);
		checkValue("pslverr(ctrl)", 32'h0, err);
		apbRead(8'h40, rd, err);
		checkValue("pslverr(unmapped)", 32'h1, err);

		// Random start PC and stores through HL
		base = 16'h1000 + Addr'($urandom % 4096);
		dataAddr = 16'h8000 + Addr'($urandom % 4096);
		n = Byte'($urandom);
		m = Byte'($urandom);
		loadPtr = base;
		putByte(OpLdHlnn);
		putWord(dataAddr);
		putByte(OpLdAn);
		putByte(n);
		putByte(OpLdHlmA);
		putByte(OpLdHliA);
		putByte(OpLdAn);
		putByte(m);
		putByte(OpLdHlmA);
		putByte(BadOp);
		startCore(base);
		waitCount = 0;
		while (memAddr == 16'h0000 && waitCount < 20)
		begin
			@(negedge clock);
			waitCount++;
		end
		if (memAddr == 16'h0000)
		begin
			$display("Timeout: no fetch address appeared after run was set");
			timeoutErrors++;
		end
		else
			checkValue("memAddr", base, memAddr);
		waitHalt();
		checkValue("mem[HL]", n, mem[dataAddr]);
		checkValue("mem[HL+1]", m, mem[dataAddr + 16'd1]);

		// ADD and SUB
		dataAddr = 16'h9000 + Addr'($urandom % 4096);
		x = Byte'($urandom);
		y = Byte'($urandom);
		expSum = x + y;
		expDiff = x - y;
		loadPtr = 16'h3000;
		putByte(OpLdHlnn);
		putWord(dataAddr);
		putByte(OpLdAn);
		putByte(x);
		putByte(OpLdBn);
		putByte(y);
		putByte(OpAddAB);
		putByte(OpLdHliA);
		putByte(OpLdAn);
		putByte(x);
		putByte(OpSubB);
		putByte(OpLdHlmA);
		putByte(BadOp);
		startCore(16'h3000);
		waitHalt();
		checkValue("mem[HL] sum", expSum, mem[dataAddr]);
		checkValue("mem[HL+1] difference", expDiff, mem[dataAddr + 16'd1]);
		apbRead(RegAAddr, rd, err);
		checkValue("regA", expDiff, rd);

		// Counted loop with HL set by a short program first
		dataAddr = 16'hA000 + Addr'($urandom % 4096);
		k = Byte'(1 + $urandom % 8);
		loadPtr = 16'h3800;
		putByte(OpLdHlnn);
		putWord(dataAddr);
		putByte(BadOp);
		startCore(16'h3800);
		waitHalt();
		loadPtr = 16'h4000;
		putByte(OpLdAn);
		putByte(8'h00);
		putByte(OpLdBn);
		putByte(k);
		putByte(OpIncA);
		putByte(OpDecB);
		putByte(OpJrNzn);
		putByte(8'hFC);  // Back to INC A
		putByte(OpLdHlmA);
		putByte(BadOp);
		startCore(16'h4000);
		waitHalt();
		checkValue("mem[HL] loop count", k, mem[dataAddr]);
		apbRead(RetiredAddr, rd, err);
		checkValue("retired", 2 + 3 * k + 1, rd);

		// Halt on the bad opcode
		apbRead(StatusAddr, rd, err);
		checkValue("status", 32'h3, rd);
		apbRead(CtrlAddr, rd, err);
		checkValue("run", 32'h0, rd);
		watchNoWrite(30);

		chkFailures = uut.chk.failures;
		$display("Error counts: %0d value, %0d timeout, %0d assertion",
			valueErrors, timeoutErrors, chkFailures);
		if (valueErrors + timeoutErrors + chkFailures == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* sim/gbCore_chk.sv */
`timescale 1ns/1ps

module gbCoreChk
(
	input logic              clock,
	input logic              rst,
	input logic              run,
	input ucodePkg::SeqState seqState,
	input logic              memWrite,
	input logic              psel,
	input logic              penable,
	input logic              pready,
	input logic              pslverr,
	input logic              retire,
	input logic              halt
);
	import ucodePkg::*;

	int failures = 0;

	// Stopped core leaves memory alone
	noWriteWhenStopped: assert property (@(posedge clock) disable iff (rst)
		(!run && seqState == idle) |-> !memWrite)
	else
	begin
		$error("memWrite high while the core is stopped and idle");
		failures++;
	end

	////////////////////
	// APB side

	readyInAccess: assert property (@(posedge clock) disable iff (rst)
		(psel && penable) |-> pready)
	else
	begin
		$error("pready low in an APB access phase");
		failures++;
	end

	errorOnlyInAccess: assert property (@(posedge clock) disable iff (rst)
		pslverr |-> (psel && penable))
	else
	begin
		$error("pslverr high outside an APB access phase");
		failures++;
	end

	// A bad opcode never retires
	haltRetireExclusive: assert property (@(posedge clock) disable iff (rst)
		!(halt && retire))
	else
	begin
		$error("halt and retire pulsed in the same cycle");
		failures++;
	end

endmodule

bind gbCore gbCoreChk chk
(
	.clock(clock),
	.rst(rst),
	.run(run),
	.seqState(sequencer.state),
	.memWrite(memWrite),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.retire(retire),
	.halt(halt)
);

/* logic/gbCore.sv */
`timescale 1ns/1ps

module gbCore
#(
	parameter int RetiredWidth = 16
)
(
	input  logic             clock,
	input  logic             rst,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  ucodePkg::ApbAddr paddr,
	input  ucodePkg::ApbData pwdata,
	output ucodePkg::ApbData prdata,
	output logic             pready,
	output logic             pslverr,
	output ucodePkg::Addr    memAddr,
	output logic             memWrite,
	output ucodePkg::Byte    memWdata,
	input  ucodePkg::Byte    memRdata
);
	import ucodePkg::*;

	// Host side
	logic run;
	logic startPcLoad;
	Addr startPc;
	logic retire;
	logic halt;
	Byte regA;

	// Sequencer to datapath
	Uop uop;
	Byte opcode;
	logic opcodeLatch;
	logic pcInc;
	logic pcLoad;
	logic zeroFlag;

	hostRegs #(.RetiredWidth(RetiredWidth)) host (.*);
	ucodeSequencer sequencer (.*);
	cpuDatapath datapath (.*);

endmodule

/* logic/hostRegs.sv */
`timescale 1ns/1ps

module hostRegs
#(
	parameter int RetiredWidth = 16
)
(
	input  logic             clock,
	input  logic             rst,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  ucodePkg::ApbAddr paddr,
	input  ucodePkg::ApbData pwdata,
	output ucodePkg::ApbData prdata,
	output logic             pready,
	output logic             pslverr,
	input  logic             retire,
	input  logic             halt,
	input  ucodePkg::Byte    regA,
	output logic             run,
	output logic             startPcLoad,
	output ucodePkg::Addr    startPc
);
	import ucodePkg::*;

	logic access;
	logic mapped;
	logic wrCtrl;
	logic wrStartPc;
	logic halted;
	logic badOpcode;
	logic [RetiredWidth-1:0] retired;

	// No wait states
	assign access = psel && penable;
	assign pready = access;
	assign pslverr = access && !mapped;
	assign wrCtrl = access && pwrite && (paddr == CtrlAddr);
	assign wrStartPc = access && pwrite && (paddr == StartPcAddr);

	// Read mux and address decode
	always_comb
	begin
		mapped = 1'b1;
		case (paddr)
			CtrlAddr:    prdata = ApbData'(run);
			StartPcAddr: prdata = ApbData'(startPc);
			StatusAddr:  prdata = ApbData'({badOpcode, halted});
			RetiredAddr: prdata = ApbData'(retired);
			RegAAddr:    prdata = ApbData'(regA);
			default:
			begin
				mapped = 1'b0;
				prdata = '0;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			run <= 1'b0;
			halted <= 1'b0;
			badOpcode <= 1'b0;
			startPcLoad <= 1'b0;
			retired <= '0;
		end
		else
		begin
			startPcLoad <= wrStartPc;
			if (wrCtrl)
			begin
				run <= pwdata[0];
				halted <= 1'b0;
				badOpcode <= 1'b0;
			end
			// Halt wins over a host write
			if (halt)
			begin
				run <= 1'b0;
				halted <= 1'b1;
				badOpcode <= 1'b1;
			end
			// New program restarts the count
			if (wrStartPc)
				retired <= '0;
			else if (retire)
				retired <= retired + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (wrStartPc)
			startPc <= pwdata[15:0];
	end

endmodule

/* logic/cpuDatapath.sv */
`timescale 1ns/1ps

module cpuDatapath
(
	input  logic          clock,
	input  logic          rst,
	input  ucodePkg::Uop  uop,
	input  logic          opcodeLatch,
	input  logic          pcInc,
	input  logic          pcLoad,
	input  ucodePkg::Addr startPc,
	input  ucodePkg::Byte memRdata,
	output ucodePkg::Addr memAddr,
	output logic          memWrite,
	output ucodePkg::Byte memWdata,
	output ucodePkg::Byte opcode,
	output logic          zeroFlag,
	output ucodePkg::Byte regA
);
	import ucodePkg::*;

	Byte regB;
	Byte regC;
	Byte regH;
	Byte regL;
	Byte scratch8;
	Addr scratch16;
	Addr pcReg;
	Addr addrReg;
	Byte opcodeReg;
	logic carryFlag;
	Addr opVal;
	Addr incDecVal;
	Addr wrVal;
	logic wrEn;
	logic isByteOperand;
	logic [8:0] aluSum;
	logic [8:0] aluDiff;

	// Operand read, x8 is always sign extended
	always_comb
	begin
		case (uop.operand)
			a:       opVal = {8'h00, regA};
			b:       opVal = {8'h00, regB};
			c:       opVal = {8'h00, regC};
			h:       opVal = {8'h00, regH};
			l:       opVal = {8'h00, regL};
			hl:      opVal = {regH, regL};
			pc:      opVal = pcReg;
			x8:      opVal = {{8{scratch8[7]}}, scratch8};
			x16:     opVal = scratch16;
			default: opVal = '0;
		endcase
	end

	assign isByteOperand = uop.operand inside {a, b, c, h, l};
	assign incDecVal = (uop.action == decReg) ? opVal - 16'd1 : opVal + 16'd1;
	assign aluSum = {1'b0, scratch16[7:0]} + {1'b0, opVal[7:0]};
	assign aluDiff = {1'b0, scratch16[7:0]} - {1'b0, opVal[7:0]};

	// Memory port, address follows setMemAddr in the same cycle
	assign memAddr = (uop.action == setMemAddr) ? opVal : addrReg;
	assign memWrite = (uop.action == ucodePkg::memWrite);
	assign memWdata = opVal[7:0];
	assign opcode = opcodeLatch ? memRdata : opcodeReg;

	always_comb
	begin
		wrEn = 1'b1;
		case (uop.action)
			loadFromMem:    wrVal = {8'h00, memRdata};
			copyFromX16:    wrVal = scratch16;
			incReg, decReg: wrVal = incDecVal;
			default:
			begin
				wrEn = 1'b0;
				wrVal = opVal;
			end
		endcase
	end

	////////////////////
	// Register file

	always_ff @(posedge clock)
	begin
		if (wrEn)
		begin
			case (uop.operand)
				a:   regA <= wrVal[7:0];
				b:   regB <= wrVal[7:0];
				c:   regC <= wrVal[7:0];
				h:   regH <= wrVal[7:0];
				l:   regL <= wrVal[7:0];
				hl:
				begin
					regH <= wrVal[15:8];
					regL <= wrVal[7:0];
				end
				x8:  scratch8 <= wrVal[7:0];
				x16: scratch16 <= wrVal;
				default: ;
			endcase
		end
		case (uop.action)
			copyToX16: scratch16 <= opVal;
			addX16:    scratch16 <= (uop.operand == x8) ? scratch16 + opVal
				: {8'h00, aluSum[7:0]};
			subX16:    scratch16 <= {8'h00, aluDiff[7:0]};
			default: ;
		endcase
		if (opcodeLatch)
			opcodeReg <= memRdata;
	end

	////////////////////
	// PC, address and flags

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			pcReg <= '0;
			addrReg <= '0;
			zeroFlag <= 1'b0;
			carryFlag <= 1'b0;
		end
		else
		begin
			if (pcLoad)
				pcReg <= startPc;
			else if (uop.action == setPc)
				pcReg <= opVal;
			else if (pcInc)
				pcReg <= pcReg + 16'd1;
			if (uop.action == setMemAddr)
				addrReg <= opVal;
			// 16-bit updates leave the flags alone
			if (isByteOperand)
			begin
				case (uop.action)
					incReg, decReg:
						zeroFlag <= (incDecVal[7:0] == 8'h00);
					addX16:
					begin
						zeroFlag <= (aluSum[7:0] == 8'h00);
						carryFlag <= aluSum[8];
					end
					subX16:
					begin
						zeroFlag <= (aluDiff[7:0] == 8'h00);
						carryFlag <= aluDiff[8];  // Borrow
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* logic/ucodeSequencer.sv */
`timescale 1ns/1ps

module ucodeSequencer
(
	input  logic          clock,
	input  logic          rst,
	input  logic          run,
	input  logic          startPcLoad,
	input  logic          zeroFlag,
	input  ucodePkg::Byte opcode,
	output ucodePkg::Uop  uop,
	output logic          opcodeLatch,
	output logic          pcInc,
	output logic          pcLoad,
	output logic          retire,
	output logic          halt
);
	import ucodePkg::*;

	SeqState state;
	FlowIdx idx;
	FlowIdx flowStart;
	logic known;
	Uop romUop;
	logic endCond;
	logic endFlow;

	opcodeLut lut (.opcode(opcode), .flowStart(flowStart), .known(known));
	ucodeRom rom (.idx(idx), .uop(romUop));

	// Does the current row close its flow
	always_comb
	begin
		case (romUop.seq)
			eof, incEof: endCond = 1'b1;
			incEofZ:     endCond = zeroFlag;
			incEofNz:    endCond = !zeroFlag;
			default:     endCond = 1'b0;
		endcase
	end

	assign endFlow = (state == execute) && endCond;
	assign retire = endFlow;
	assign opcodeLatch = (state == fetchWait);
	assign halt = (state == fetchWait) && !known;
	assign pcLoad = startPcLoad && (state == idle);

	// Opcode byte is skipped during fetchAddr
	assign pcInc = (state == fetchAddr) ||
		((state == execute) && romUop.seq != op && romUop.seq != eof);

	always_comb
	begin
		case (state)
			fetchAddr: uop = '{op, setMemAddr, pc};
			execute:   uop = romUop;
			default:   uop = '{op, nop, none};
		endcase
	end

	////////////////////
	// State machine

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= idle;
			idx <= '0;
		end
		else
		begin
			case (state)
				idle:
					if (run)
						state <= fetchAddr;
				fetchAddr:
					state <= fetchWait;
				fetchWait:
				begin
					idx <= flowStart;
					state <= known ? execute : idle;
				end
				default:
				begin
					if (endCond)
						state <= run ? fetchAddr : idle;
					else
						idx <= idx + FlowIdx'(1);
				end
			endcase
		end
	end

endmodule

/* logic/ucodeRom.sv */
`timescale 1ns/1ps

module ucodeRom
(
	input  ucodePkg::FlowIdx idx,
	output ucodePkg::Uop     uop
);
	import ucodePkg::*;

	// PC already points past the opcode when a flow starts
	always_comb
	begin
		case (idx)
		//NOP
			0:  uop = '{eof,      nop,         none};
		//LD A,n
			1:  uop = '{op,       setMemAddr,  pc};
			2:  uop = '{incEof,   loadFromMem, a};
		//LD B,n
			3:  uop = '{op,       setMemAddr,  pc};
			4:  uop = '{incEof,   loadFromMem, b};
		//LD C,n
			5:  uop = '{op,       setMemAddr,  pc};
			6:  uop = '{incEof,   loadFromMem, c};
		//LD HL,nn
			7:  uop = '{inc,      setMemAddr,  pc};
			8:  uop = '{op,       loadFromMem, l};
			9:  uop = '{inc,      setMemAddr,  pc};
			10: uop = '{eof,      loadFromMem, h};
		//LD (HL),A
			11: uop = '{op,       setMemAddr,  hl};
			12: uop = '{eof,      memWrite,    a};
		//LD (HL+),A
			13: uop = '{op,       setMemAddr,  hl};
			14: uop = '{op,       memWrite,    a};
			15: uop = '{eof,      incReg,      hl};
		//INC r
			16: uop = '{eof,      incReg,      a};
			17: uop = '{eof,      incReg,      b};
			18: uop = '{eof,      incReg,      c};
		//DEC r
			19: uop = '{eof,      decReg,      a};
			20: uop = '{eof,      decReg,      b};
			21: uop = '{eof,      decReg,      c};
		//ADD A,B
			22: uop = '{op,       copyToX16,   a};
			23: uop = '{op,       addX16,      b};
			24: uop = '{eof,      copyFromX16, a};
		//SUB B
			25: uop = '{op,       copyToX16,   a};
			26: uop = '{op,       subX16,      b};
			27: uop = '{eof,      copyFromX16, a};
		//JR n
			28: uop = '{op,       setMemAddr,  pc};
			29: uop = '{inc,      loadFromMem, x8};
			30: uop = '{op,       copyToX16,   pc};
			31: uop = '{op,       addX16,      x8};  // x16 = pc + signed offset
			32: uop = '{eof,      setPc,       x16};
		//JR NZ,n
			33: uop = '{op,       setMemAddr,  pc};
			34: uop = '{incEofZ,  loadFromMem, x8};  // Z set, fall through
			35: uop = '{op,       copyToX16,   pc};
			36: uop = '{op,       addX16,      x8};
			37: uop = '{eof,      setPc,       x16};
		//JP nn
			38: uop = '{op,       copyToX16,   hl};  // HL is borrowed for the target
			39: uop = '{inc,      setMemAddr,  pc};
			40: uop = '{op,       loadFromMem, l};
			41: uop = '{op,       setMemAddr,  pc};
			42: uop = '{op,       loadFromMem, h};
			43: uop = '{op,       setPc,       hl};
			44: uop = '{eof,      copyFromX16, hl};
			default:
				uop = '{op, nop, none};
		endcase
	end

endmodule

/* logic/opcodeLut.sv */
`timescale 1ns/1ps

module opcodeLut
(
	input  ucodePkg::Byte    opcode,
	output ucodePkg::FlowIdx flowStart,
	output logic             known
);
	import ucodePkg::*;

	// First ROM row of each flow
	always_comb
	begin
		known = 1'b1;
		case (opcode)
			OpNop:    flowStart = 7'd0;
			OpLdAn:   flowStart = 7'd1;
			OpLdBn:   flowStart = 7'd3;
			OpLdCn:   flowStart = 7'd5;
			OpLdHlnn: flowStart = 7'd7;
			OpLdHlmA: flowStart = 7'd11;
			OpLdHliA: flowStart = 7'd13;
			OpIncA:   flowStart = 7'd16;
			OpIncB:   flowStart = 7'd17;
			OpIncC:   flowStart = 7'd18;
			OpDecA:   flowStart = 7'd19;
			OpDecB:   flowStart = 7'd20;
			OpDecC:   flowStart = 7'd21;
			OpAddAB:  flowStart = 7'd22;
			OpSubB:   flowStart = 7'd25;
			OpJrn:    flowStart = 7'd28;
			OpJrNzn:  flowStart = 7'd33;
			OpJpnn:   flowStart = 7'd38;
			default:
			begin
				// Not in the table, the sequencer halts
				known = 1'b0;
				flowStart = 7'd0;
			end
		endcase
	end

endmodule

/* logic/ucodePkg.sv */
package ucodePkg;

	////////////////////
	// Widths

	localparam int ApbAddrWidth = 8;
	localparam int ApbDataWidth = 32;

	typedef logic [7:0] Byte;
	typedef logic [15:0] Addr;
	typedef logic [6:0] FlowIdx;
	typedef logic [ApbAddrWidth-1:0] ApbAddr;
	typedef logic [ApbDataWidth-1:0] ApbData;

	////////////////////
	// Micro-op fields

	// Sequencer step kind, conditional kinds test the Z flag
	typedef enum logic [2:0] {op, inc, eof, incEof, incEofZ, incEofNz} SeqOp;

	typedef enum logic [3:0] {nop, setMemAddr, memWrite, loadFromMem, copyToX16,
		copyFromX16, addX16, subX16, incReg, decReg, setPc} UopAction;

	typedef enum logic [3:0] {a, b, c, h, l, hl, pc, x8, x16, none} UopOperand;

	typedef struct packed
	{
		SeqOp seq;
		UopAction action;
		UopOperand operand;
	} Uop;

	typedef enum logic [1:0] {idle, fetchAddr, fetchWait, execute} SeqState;

	////////////////////
	// Opcodes

	localparam Byte OpNop = 8'h00;
	localparam Byte OpLdAn = 8'h3E;
	localparam Byte OpLdBn = 8'h06;
	localparam Byte OpLdCn = 8'h0E;
	localparam Byte OpLdHlnn = 8'h21;
	localparam Byte OpLdHlmA = 8'h77;
	localparam Byte OpLdHliA = 8'h22;
	localparam Byte OpIncA = 8'h3C;
	localparam Byte OpIncB = 8'h04;
	localparam Byte OpIncC = 8'h0C;
	localparam Byte OpDecA = 8'h3D;
	localparam Byte OpDecB = 8'h05;
	localparam Byte OpDecC = 8'h0D;
	localparam Byte OpAddAB = 8'h80;
	localparam Byte OpSubB = 8'h90;
	localparam Byte OpJrn = 8'h18;
	localparam Byte OpJrNzn = 8'h20;
	localparam Byte OpJpnn = 8'hC3;

	// Host register offsets
	localparam ApbAddr CtrlAddr = 8'h00;
	localparam ApbAddr StartPcAddr = 8'h04;
	localparam ApbAddr StatusAddr = 8'h08;
	localparam ApbAddr RetiredAddr = 8'h0C;
	localparam ApbAddr RegAAddr = 8'h10;

endpackage
